// File: dial_defs.svh
// ----------------------------------------
// Width macros for the dial chain.
// Sensitivity tables for burst and pacing.
// Joystick button bit positions.
// ----------------------------------------
`ifndef DIAL_DEFS_SVH
`define DIAL_DEFS_SVH

`define DIAL_PHASE_W    2       // One quadrature phase pair.
`define DIAL_POS_W      12      // Signed position counter width.
`define DIAL_BURST_W    5       // Holds the longest burst of 26 steps.
`define DIAL_LINE_W     3       // Eight line slots per pacing group.

// Spinner burst length, indexed by sensitivity.
`define DIAL_BURST_S0   18
`define DIAL_BURST_S1   26
`define DIAL_BURST_S2   2
`define DIAL_BURST_S3   10

// Joystick due slots out of every eight lines.
`define DIAL_DUE_S0     5
`define DIAL_DUE_S1     7
`define DIAL_DUE_S2     1
`define DIAL_DUE_S3     3

`define DIAL_JOY_RIGHT  5       // Active low right button.
`define DIAL_JOY_LEFT   6       // Active low left button.

`endif

// File: dial_pkg.sv
// ----------------------------------------
// Shared types for the dial chain.
// Phase, position and input word types.
// Pacer state encoding.
// ----------------------------------------
`default_nettype none

`include "dial_defs.svh"

package dial_pkg;

    // Quadrature outputs use a Gray coded pair per axis.
    typedef logic [`DIAL_PHASE_W-1:0]        dial_phase_t;

    // Position wraps like the counter chip it mimics.
    typedef logic signed [`DIAL_POS_W-1:0]   dial_pos_t;

    typedef logic [1:0]                      sensty_t;     // Dial sensitivity select.
    typedef logic [6:0]                      joy_t;        // Buttons, active low.

    // Bit 8 toggles once per spinner event, bit 7 is set for left turns.
    typedef logic [8:0]                      spin_t;

    // ----------------------------------------
    // Line pacer FSM
    // ----------------------------------------
    typedef enum logic [1:0] {
        pacer_idle,         // Waiting for blanking to go low after reset.
        pacer_wait_line,    // Waiting for the start of the first full line.
        pacer_slot          // Counting line slots and issuing strobes.
    } pacer_state_t;

endpackage

`default_nettype wire

// File: dial_line_pacer.sv
// ----------------------------------------
// Line pacer for the joystick dial rate.
// Detects line starts from LHBL and marks
// the due slots in each group of 8 lines.
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "dial_defs.svh"

module dial_line_pacer import dial_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    LHBL,
    input  sensty_t sensty,
    output logic    line,
    output logic    joy_due
);

    pacer_state_t              state;          // Start-up sequencing.
    logic                      lhbl_l;         // LHBL one cycle late.
    logic                      rise;           // Blanking has just ended.
    logic [`DIAL_LINE_W-1:0]   slot_idx;       // Position inside the 8 line group.
    logic [`DIAL_LINE_W-1:0]   due_lim;        // Slots below this one are due.

    assign rise = LHBL & ~lhbl_l;              // A new line starts here.

    // ----------------------------------------
    // Due threshold per sensitivity
    // ----------------------------------------
    always_comb begin
        case (sensty)
            2'd0:    due_lim = `DIAL_LINE_W'(`DIAL_DUE_S0);
            2'd1:    due_lim = `DIAL_LINE_W'(`DIAL_DUE_S1);
            2'd2:    due_lim = `DIAL_LINE_W'(`DIAL_DUE_S2);
            default: due_lim = `DIAL_LINE_W'(`DIAL_DUE_S3);
        endcase
    end

    // ----------------------------------------
    // Line detection and slot counting
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= pacer_idle;
            lhbl_l   <= 1'b0;
            slot_idx <= '0;
            line     <= 1'b0;
            joy_due  <= 1'b0;
        end else begin
            lhbl_l  <= LHBL;
            line    <= 1'b0;                   // Both strobes last one cycle.
            joy_due <= 1'b0;
            case (state)
                pacer_idle: begin
                    if (!LHBL) state <= pacer_wait_line;   // Now the next rise is real.
                end
                pacer_wait_line: begin
                    if (rise) state <= pacer_slot;         // The first full line begins.
                end
                pacer_slot: begin
                    if (rise) begin
                        line     <= 1'b1;
                        joy_due  <= slot_idx < due_lim;    // Same cycle as line.
                        slot_idx <= slot_idx + 1'b1;       // Wraps every eight lines.
                    end
                end
                default: state <= pacer_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: dial_step_decode.sv
// ----------------------------------------
// Decode stage for one player.
// Joystick levels and spinner toggles turn
// into step strobes with a direction.
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "dial_defs.svh"

module dial_step_decode import dial_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  joy_t    joy,
    input  spin_t   spin,
    input  sensty_t sensty,
    input  logic    joy_due,
    output logic    step,
    output logic    step_dir
);

    logic                      spin_l;         // Spinner event bit one cycle late.
    logic                      toggle;         // A spinner event arrived.
    logic                      press_r;        // Right button held.
    logic                      press_l;        // Left button held.
    logic                      joy_step;       // Joystick step taken this cycle.
    logic                      burst_en;       // Alternates to halve the burst rate.
    logic                      burst_go;       // Burst step taken this cycle.
    logic                      burst_dir;      // Burst direction, set for increment.
    logic [`DIAL_BURST_W-1:0]  burst_cnt;      // Steps left in the burst.
    logic [`DIAL_BURST_W-1:0]  burst_len;      // Reload value for a new burst.

    // ----------------------------------------
    // Input decoding
    // ----------------------------------------
    assign toggle  = spin[8] != spin_l;        // Either edge marks one event.
    assign press_r = ~joy[`DIAL_JOY_RIGHT];    // Buttons are active low.
    assign press_l = ~joy[`DIAL_JOY_LEFT];

    // Both buttons or none cancel each other out.
    assign joy_step = joy_due & (press_r ^ press_l);

    // The joystick wins the cycle. A fresh toggle restarts the burst first.
    assign burst_go = burst_en & (burst_cnt != '0) & ~joy_step & ~toggle;

    always_comb begin
        case (sensty)
            2'd0:    burst_len = `DIAL_BURST_W'(`DIAL_BURST_S0);
            2'd1:    burst_len = `DIAL_BURST_W'(`DIAL_BURST_S1);
            2'd2:    burst_len = `DIAL_BURST_W'(`DIAL_BURST_S2);
            default: burst_len = `DIAL_BURST_W'(`DIAL_BURST_S3);
        endcase
    end

    // ----------------------------------------
    // Burst counter and step arbitration
    // ----------------------------------------
    always_ff @(posedge clk) begin
        spin_l <= spin[8];                     // Tracks the input even in reset.
        if (toggle) begin
            burst_dir <= ~spin[7];             // Bit 7 set means a left turn.
        end
        if (reset) begin
            burst_en  <= 1'b0;
            burst_cnt <= '0;
            step      <= 1'b0;
            step_dir  <= 1'b0;
        end else begin
            burst_en <= ~burst_en;             // Free running half rate enable.
            step     <= joy_step | burst_go;   // One cycle after the decision.
            if (joy_step) begin
                step_dir <= press_r;           // Right turns count up.
            end else if (burst_go) begin
                step_dir <= burst_dir;
            end
            if (toggle) begin
                burst_cnt <= burst_len;        // Any running burst is dropped.
            end else if (burst_go) begin
                burst_cnt <= burst_cnt - 1'b1; // Skipped when the joystick stepped.
            end
        end
    end

endmodule

`default_nettype wire

// File: dial_quad_gen.sv
// ----------------------------------------
// Execute stage of the dial chain.
// Moves a quadrature pair one quarter per
// step in the requested direction.
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "dial_defs.svh"

module dial_quad_gen import dial_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        step,
    input  logic        step_dir,
    output dial_phase_t phase
);

    logic [`DIAL_PHASE_W-1:0]  idx;            // Binary position within one cycle.

    // ----------------------------------------
    // Position index
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            idx <= '0;                         // Phase starts at 00.
        end else if (step) begin
            if (step_dir) begin
                idx <= idx + 1'b1;             // Forward quarter.
            end else begin
                idx <= idx - 1'b1;             // Backward quarter.
            end
        end
    end

    // ----------------------------------------
    // Gray output
    // ----------------------------------------
    // Index 0 to 3 gives 00, 01, 11, 10, so each
    // move flips exactly one line of the pair.
    assign phase = {idx[1], idx[1] ^ idx[0]};

endmodule

`default_nettype wire

// File: dial_quad_counter.sv
// ----------------------------------------
// Result stage of the dial chain.
// Decodes quadrature changes into a signed
// position count with a clear input.
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "dial_defs.svh"

module dial_quad_counter import dial_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  dial_phase_t phase,
    input  logic        clear,
    output dial_pos_t   pos
);

    dial_phase_t               phase_l;        // Phase seen on the previous cycle.
    logic [`DIAL_PHASE_W-1:0]  bin_now;        // Current phase as a binary index.
    logic [`DIAL_PHASE_W-1:0]  bin_old;        // Previous phase as a binary index.
    logic [`DIAL_PHASE_W-1:0]  delta;          // Quarter steps moved, modulo four.
    logic                      fwd;            // One quarter forward.
    logic                      rev;            // One quarter backward.

    // ----------------------------------------
    // Transition classification
    // ----------------------------------------
    // Gray to binary turns 00, 01, 11, 10 into 0 to 3.
    assign bin_now = {phase[1], phase[1] ^ phase[0]};
    assign bin_old = {phase_l[1], phase_l[1] ^ phase_l[0]};
    assign delta   = bin_now - bin_old;

    // A delta of two means both lines flipped, which
    // cannot be told apart, so it counts as nothing.
    assign fwd = delta == `DIAL_PHASE_W'(1);
    assign rev = delta == `DIAL_PHASE_W'(3);

    // ----------------------------------------
    // Position count
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            phase_l <= '0;                     // Matches the generator reset phase.
            pos     <= '0;
        end else begin
            phase_l <= phase;
            if (clear) begin
                pos <= '0;                     // Clear beats a transition.
            end else if (fwd) begin
                pos <= pos + dial_pos_t'(1);   // Wraps at the counter width.
            end else if (rev) begin
                pos <= pos - dial_pos_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: dial_top.sv
// ----------------------------------------
// Top level of the two player dial.
// Player 1 drives the x chain and player 2
// drives the y chain.
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dial_top import dial_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        LHBL,
    input  sensty_t     sensty,
    input  joy_t        joystick1,
    input  joy_t        joystick2,
    input  spin_t       spinner_1,
    input  spin_t       spinner_2,
    input  logic        clear,
    output dial_phase_t dial_x,
    output dial_phase_t dial_y,
    output dial_pos_t   pos_x,
    output dial_pos_t   pos_y
);

    logic   joy_due;                           // Shared joystick pacing strobe.
    logic   step_x;
    logic   step_dir_x;
    logic   step_y;
    logic   step_dir_y;

    // ----------------------------------------
    // Shared pacing
    // ----------------------------------------
    dial_line_pacer u_pacer (
        .clk      (clk),
        .reset    (reset),
        .LHBL     (LHBL),
        .sensty   (sensty),
        .line     (),                          // The decoders only need joy_due.
        .joy_due  (joy_due)
    );

    // ----------------------------------------
    // Player 1, x axis
    // ----------------------------------------
    dial_step_decode u_decode_x (
        .clk      (clk),
        .reset    (reset),
        .joy      (joystick1),
        .spin     (spinner_1),
        .sensty   (sensty),
        .joy_due  (joy_due),
        .step     (step_x),
        .step_dir (step_dir_x)
    );

    dial_quad_gen u_gen_x (
        .clk      (clk),
        .reset    (reset),
        .step     (step_x),
        .step_dir (step_dir_x),
        .phase    (dial_x)
    );

    dial_quad_counter u_count_x (
        .clk      (clk),
        .reset    (reset),
        .phase    (dial_x),
        .clear    (clear),
        .pos      (pos_x)
    );

    // ----------------------------------------
    // Player 2, y axis
    // ----------------------------------------
    dial_step_decode u_decode_y (
        .clk      (clk),
        .reset    (reset),
        .joy      (joystick2),
        .spin     (spinner_2),
        .sensty   (sensty),
        .joy_due  (joy_due),
        .step     (step_y),
        .step_dir (step_dir_y)
    );

    dial_quad_gen u_gen_y (
        .clk      (clk),
        .reset    (reset),
        .step     (step_y),
        .step_dir (step_dir_y),
        .phase    (dial_y)
    );

    dial_quad_counter u_count_y (
        .clk      (clk),
        .reset    (reset),
        .phase    (dial_y),
        .clear    (clear),
        .pos      (pos_y)
    );

endmodule

`default_nettype wire

// File: dial_assert.sv
// ----------------------------------------
// Concurrent checks on step strobes and
// quadrature phase moves, bound into the
// decode and execute stages.
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dial_assert import dial_pkg::*; #(
    parameter bit EXEC = 1'b0                  // Set when bound into the generator.
) (
    input logic        clk,
    input logic        reset,
    input logic        step,
    input logic        step_dir,
    input logic        joy_due,
    input dial_phase_t phase
);

    generate
        if (!EXEC) begin : g_decode
            // Bursts use every second cycle, so back to back steps need a joystick step.
            a_step_len: assert property (@(posedge clk) disable iff (reset)
                (step && $past(step)) |-> ($past(joy_due) || $past(joy_due, 2)))
                else $error("back to back steps without a joystick step");

            a_dir_hold: assert property (@(posedge clk) disable iff (reset)
                step_dir != $past(step_dir) |-> step)
                else $error("step_dir changed without a step");     // Direction rides with step.
        end else begin : g_exec
            a_phase_gray: assert property (@(posedge clk) disable iff (reset)
                phase != $past(phase) |-> $onehot(phase ^ $past(phase)))
                else $error("phase moved by more than one line");   // Gray steps only.

            // The pair moves exactly one cycle after each step strobe.
            a_phase_move: assert property (@(posedge clk) disable iff (reset)
                (phase != $past(phase)) == $past(step))
                else $error("phase move does not follow a step strobe");
        end
    endgenerate

endmodule

// Step rules live in the decoder, phase rules in the generator.
bind dial_step_decode dial_assert #(.EXEC(1'b0)) u_decode_assert (
    .clk      (clk),
    .reset    (reset),
    .step     (step),
    .step_dir (step_dir),
    .joy_due  (joy_due),
    .phase    (2'b00)
);

bind dial_quad_gen dial_assert #(.EXEC(1'b1)) u_gen_assert (
    .clk      (clk),
    .reset    (reset),
    .step     (step),
    .step_dir (step_dir),
    .joy_due  (1'b0),
    .phase    (phase)
);

`default_nettype wire

// File: tb_dial.sv
// ----------------------------------------
// Testbench for the two player dial.
// Random lines, joystick holds and spinner
// events checked against a pacer and burst
// model plus a Gray decoder of the outputs.
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_dial import dial_pkg::*; ();

    localparam int LINE_MAX    = 34;               // Longest generated line in cycles.
    localparam int SETTLE      = 120;              // Longest burst plus the pipeline.
    localparam int ITERS       = 8;                // Two rounds over every sensitivity.
    localparam int TEST_CYCLES = 10 + 2 * LINE_MAX + ITERS * (3 * SETTLE + 70 * LINE_MAX + 82)
                               + 4 * LINE_MAX + 2 * SETTLE + 62;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 2000) * 4;

    logic        clk = 1'b0;
    logic        reset;
    logic        lhbl;
    sensty_t     sensty;
    joy_t        joystick1;
    joy_t        joystick2;
    spin_t       spinner_1;
    spin_t       spinner_2;
    logic        clear;
    dial_phase_t dial_x;
    dial_phase_t dial_y;
    dial_pos_t   pos_x;
    dial_pos_t   pos_y;

    int          due_tab[4]   = '{5, 7, 1, 3};     // Due lines in each group of eight.
    int          burst_tab[4] = '{18, 26, 2, 10};  // Steps per spinner event.
    int          errors;
    int          r;
    bit          pacer_armed;                      // The first rise after reset only arms it.
    int          slot;                             // Model slot index, modulo 8.
    int          joy_x;                            // Joystick steps expected in a test.
    int          joy_y;
    int          bx;                               // Burst of the latest spinner event.
    int          by;
    int          hx;                               // Held joystick direction.
    int          hy;
    int          dx;
    int          dy;
    dial_pos_t   acc_x;                            // Count rebuilt from observed phases.
    dial_pos_t   acc_y;
    dial_pos_t   start_x;
    dial_pos_t   start_y;
    dial_phase_t prev_x;
    dial_phase_t prev_y;

    always #2 clk = ~clk;                          // 4 ns period.

    dial_top dut (
        .clk       (clk),
        .reset     (reset),
        .LHBL      (lhbl),
        .sensty    (sensty),
        .joystick1 (joystick1),
        .joystick2 (joystick2),
        .spinner_1 (spinner_1),
        .spinner_2 (spinner_2),
        .clear     (clear),
        .dial_x    (dial_x),
        .dial_y    (dial_y),
        .pos_x     (pos_x),
        .pos_y     (pos_y)
    );

    // ----------------------------------------
    // Compare tasks and model helpers
    // ----------------------------------------
    task automatic compare_phase(input string name, input dial_phase_t exp, input dial_phase_t act);
        if (exp !== act) begin
            errors++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic compare_pos(input string name, input dial_pos_t exp, input dial_pos_t act);
        if (exp !== act) begin
            errors++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    function automatic int quarter(input dial_phase_t p);
        case (p)
            2'b00:   return 0;                     // Gray order 00, 01, 11, 10.
            2'b01:   return 1;
            2'b11:   return 2;
            default: return 3;
        endcase
    endfunction

    // Signed quarter move between two samples; a two quarter jump is reported.
    function automatic int gray_delta(input string name, input dial_phase_t old_p,
                                      input dial_phase_t new_p);
        int d;
        d = (quarter(new_p) - quarter(old_p) + 4) % 4;
        if (d == 2) begin
            errors++;
            $display("%s flipped both phase lines at once, from %b to %b", name, old_p, new_p);
        end
        return (d == 1) ? 1 : ((d == 3) ? -1 : 0);
    endfunction

    function automatic int held_dir(input joy_t j);
        if (!j[5] && j[6]) return 1;               // Right alone counts up.
        if (j[5] && !j[6]) return -1;              // Left alone counts down.
        return 0;
    endfunction

    function automatic joy_t joy_word(input logic [1:0] mode);
        joy_t j;
        j    = 7'h7f;                              // All buttons released.
        j[5] = ~mode[0];
        j[6] = ~mode[1];
        return j;
    endfunction

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;                                        // Inputs change just after the edge.
    endtask

    // One line start as the pacer sees it.
    task automatic pace_line();
        if (!pacer_armed) begin
            pacer_armed = 1'b1;
        end else begin
            if (slot < due_tab[sensty]) begin
                joy_x += held_dir(joystick1);
                joy_y += held_dir(joystick2);
            end
            slot = (slot + 1) % 8;
        end
    endtask

    task automatic run_lines(input int n);
        for (int i = 0; i < n; i++) begin
            lhbl = 1'b0;
            tick(4 + int'($urandom % 8));          // Blanking part of the line.
            lhbl = 1'b1;
            pace_line();
            tick(12 + int'($urandom % 12));
        end
        lhbl = 1'b0;
    endtask

    task automatic spin_event();
        r         = $urandom;
        spinner_1 = {~spinner_1[8], r[0], 7'd0};   // Bit 7 set turns left.
        spinner_2 = {~spinner_2[8], r[1], 7'd0};
        bx        = r[0] ? -burst_tab[sensty] : burst_tab[sensty];
        by        = r[1] ? -burst_tab[sensty] : burst_tab[sensty];
    endtask

    task automatic mark_start();
        @(negedge clk);
        start_x = pos_x;
        start_y = pos_y;
        joy_x   = 0;
        joy_y   = 0;
        tick(1);
    endtask

    task automatic check_delta(input string name, input int exp_x, input int exp_y);
        @(negedge clk);
        compare_pos({name, " x"}, dial_pos_t'(exp_x), pos_x - start_x);
        compare_pos({name, " y"}, dial_pos_t'(exp_y), pos_y - start_y);
        tick(1);
    endtask

    // ----------------------------------------
    // Per cycle Gray decoder of the outputs
    // ----------------------------------------
    always @(negedge clk) begin
        if (reset) begin
            acc_x  = '0;
            acc_y  = '0;
            prev_x = dial_x;
            prev_y = dial_y;
        end else begin
            compare_pos("pos_x tracking", acc_x, pos_x);   // Lags the phase by a cycle.
            compare_pos("pos_y tracking", acc_y, pos_y);
            dx     = gray_delta("dial_x", prev_x, dial_x);
            dy     = gray_delta("dial_y", prev_y, dial_y);
            acc_x  = clear ? '0 : acc_x + dial_pos_t'(dx); // Clear drops this move.
            acc_y  = clear ? '0 : acc_y + dial_pos_t'(dy);
            prev_x = dial_x;
            prev_y = dial_y;
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'hac5c));
        errors      = 0;
        reset       = 1'b1;
        lhbl        = 1'b0;
        sensty      = 2'd0;
        joystick1   = 7'h7f;
        joystick2   = 7'h7f;
        spinner_1   = '0;
        spinner_2   = '0;
        clear       = 1'b0;
        pacer_armed = 1'b0;
        slot        = 0;
        tick(10);
        reset = 1'b0;
        @(negedge clk);
        compare_phase("reset dial_x", 2'b00, dial_x);
        compare_phase("reset dial_y", 2'b00, dial_y);
        compare_pos("reset pos_x", '0, pos_x);
        compare_pos("reset pos_y", '0, pos_y);
        tick(1);
        run_lines(2);                              // The first line arms the pacer.
        tick(SETTLE);
        for (int iter = 0; iter < ITERS; iter++) begin
            sensty = iter[1:0];
            mark_start();                          // A lone spinner event.
            spin_event();
            tick(SETTLE);
            check_delta("spin burst", bx, by);
            mark_start();                          // Joystick held over 64 lines.
            r         = $urandom;
            joystick1 = joy_word(r[1:0]);
            joystick2 = joy_word(r[3:2]);
            hx        = held_dir(joystick1);
            hy        = held_dir(joystick2);
            run_lines(64);
            joystick1 = 7'h7f;
            joystick2 = 7'h7f;
            tick(SETTLE);
            check_delta("joystick 64 lines", hx * 8 * due_tab[sensty], hy * 8 * due_tab[sensty]);
            mark_start();                          // Joystick steps inside a burst.
            r         = $urandom;
            joystick1 = joy_word(r[5:4]);
            joystick2 = joy_word(r[7:6]);
            fork
                run_lines(6);
                begin
                    tick(20 + int'($urandom % 60));
                    spin_event();
                end
            join
            joystick1 = 7'h7f;
            joystick2 = 7'h7f;
            tick(SETTLE);
            check_delta("joystick during burst", joy_x + bx, joy_y + by);
        end
        r         = $urandom;                      // Clear in the middle of activity.
        joystick1 = joy_word(r[1:0]);
        joystick2 = joy_word(r[3:2]);
        spin_event();
        fork
            run_lines(4);
            begin
                tick(30 + int'($urandom % 30));
                clear = 1'b1;
                tick(1);
                clear = 1'b0;
                @(negedge clk);
                compare_pos("clear pos_x", '0, pos_x);
                compare_pos("clear pos_y", '0, pos_y);
            end
        join
        joystick1 = 7'h7f;
        joystick2 = 7'h7f;
        tick(SETTLE);
        $display("tests done, %0d errors", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the test sequence completed");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: Makefile
# Verilator build and run for the dial testbench.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_dial
FLIST     := list.f

BIN  := obj_dir/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FLIST))) $(wildcard *.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: list.f
+incdir+.
dial_pkg.sv
dial_line_pacer.sv
dial_step_decode.sv
dial_quad_gen.sv
dial_quad_counter.sv
dial_top.sv
dial_assert.sv
tb_dial.sv
